// ==== rtl/eth_crc_cfg.svh ====
`ifndef ETH_CRC_CFG_SVH
`define ETH_CRC_CFG_SVH

////////////////////////////////////////////////////////////
// Stream geometry

// Bytes per beat
// The CRC engine stages are built around a 16-byte word
`define ETH_BEAT_BYTES 16

////////////////////////////////////////////////////////////
// Buffering

// Beat FIFO between the admit gate and the join stage
`define ETH_BEAT_FIFO_DEPTH 16

// CRC result FIFO, also the cap on frames holding a credit
`define ETH_CRC_FIFO_DEPTH 4

////////////////////////////////////////////////////////////
// CRC engine

// Accept edge of a last beat to the result strobe, in cycles
`define ETH_CRC_LATENCY 5

`endif

// ==== rtl/eth_crc_pkg.sv ====
`include "eth_crc_cfg.svh"

package eth_crc_pkg;

	////////////////////////////////////////////////////////////
	// Constants

	// Width of one beat in bits
	localparam int BEAT_BITS = `ETH_BEAT_BYTES * 8;

	// Start value of every frame
	localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;

	// Polynomial 0x04C11DB7, bit reversed for the LSB-first shift
	localparam logic [31:0] CRC_POLY_REFL = 32'hEDB8_8320;

	////////////////////////////////////////////////////////////
	// Types

	typedef logic [31:0] crc_t;

	// One beat, byte 0 of the beat in data[BEAT_BITS-1 -: 8]
	typedef struct packed {
		logic [BEAT_BITS-1:0] data;
		// Valid byte count, 1..16, only looked at on the last beat
		logic [4:0] bytes;
		logic last;
	} beat_t;

	////////////////////////////////////////////////////////////
	// CRC step functions

	// Advance the reflected state by one byte, LSB first
	function automatic crc_t crc32_byte(crc_t state, logic [7:0] b);
		crc_t c;
		c = state ^ {24'h0, b};
		for (int k = 0; k < 8; k++) begin
			if (c[0])
				c = (c >> 1) ^ CRC_POLY_REFL;
			else
				c = c >> 1;
		end
		return c;
	endfunction

	// Advance over the first nbytes bytes of a left-aligned word
	// Shorter words are passed in padded with zeros at the bottom
	function automatic crc_t crc32_bytes(crc_t state, logic [BEAT_BITS-1:0] data,
			logic [4:0] nbytes);
		crc_t c;
		c = state;
		for (int i = 0; i < `ETH_BEAT_BYTES; i++) begin
			if (i < nbytes)
				c = crc32_byte(c, data[BEAT_BITS-1-8*i -: 8]);
		end
		return c;
	endfunction

endpackage

// ==== rtl/eth_beat_if.sv ====
`timescale 1ns/10ps

// One stream beat with valid/ready handshake
interface eth_beat_if import eth_crc_pkg::*; (
	input logic clk,
	input logic reset
);

	logic valid;
	logic ready;
	beat_t beat;

	// Producer side, holds valid and beat until ready
	modport source (
		output valid,
		output beat,
		input ready
	);

	// Consumer side
	// Clock and reset come along for checks at the consumer
	modport sink (
		input clk,
		input reset,
		input valid,
		input beat,
		output ready
	);

endinterface

// ==== rtl/stream_fifo.sv ====
`timescale 1ns/10ps

module stream_fifo #(
	parameter type payload_t = logic,
	parameter int DEPTH = 4
) (
	input logic clk,
	input logic reset,
	input logic wr_valid,
	output logic wr_ready,
	input payload_t wr_data,
	output logic rd_valid,
	input logic rd_ready,
	output payload_t rd_data
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic do_wr;
	logic do_rd;

	// Circular pointer step, wraps at DEPTH
	function automatic logic [AW-1:0] next_ptr(logic [AW-1:0] p);
		return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// Full and empty straight from the count
	assign wr_ready = (count != CW'(DEPTH));
	assign rd_valid = (count != '0);
	assign rd_data = mem[rd_ptr];

	assign do_wr = wr_valid && wr_ready;
	assign do_rd = rd_valid && rd_ready;

	// Storage
	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	// Pointers and fill level
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_rd)
				rd_ptr <= next_ptr(rd_ptr);
			// Simultaneous read and write leaves the level alone
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (!do_wr && do_rd)
				count <= count - 1'b1;
		end
	end

	// Writers never push into a full buffer, the CRC side has no ready at all
	a_no_overflow: assert property (
		@(posedge clk) disable iff (reset) wr_valid |-> wr_ready
	);

endmodule

// ==== rtl/crc32_x128_pipe.sv ====
`timescale 1ns/10ps
`include "eth_crc_cfg.svh"

module crc32_x128_pipe import eth_crc_pkg::*; (
	input logic clk,
	input logic reset,
	input logic update,
	input logic last,
	input logic [4:0] bytes,
	input logic [BEAT_BITS-1:0] data,
	output logic res_valid,
	output crc_t res_crc
);

	////////////////////////////////////////////////////////////
	// Running state over full beats

	// Reflected CRC of all beats of the current frame so far
	crc_t crc_run;
	crc_t crc_full;

	// Whole 16-byte step on the incoming beat
	assign crc_full = crc32_bytes(crc_run, data, 5'd16);

	always_ff @(posedge clk) begin
		if (reset) begin
			crc_run <= CRC_INIT;
		end else if (update) begin
			// Last beat goes down the tail and the next beat starts a new frame
			if (last)
				crc_run <= CRC_INIT;
			else
				crc_run <= crc_full;
		end
	end

	////////////////////////////////////////////////////////////
	// Tail pipeline for the last beat

	// Stage 0 captures the pre-beat state and data
	logic s0_valid;
	logic s0_done;
	crc_t s0_crc;
	crc_t s0_state;
	logic [BEAT_BITS-1:0] s0_data;
	logic [3:0] s0_len;
	crc_t s0_x64;

	// Stage 1 holds the registered x64 result
	logic s1_valid;
	logic s1_done;
	crc_t s1_crc;
	crc_t s1_state;
	logic [BEAT_BITS-1:0] s1_data;
	logic [3:0] s1_len;
	crc_t s1_x64;

	// Stage 2 has the half selected with 0..7 bytes left
	logic s2_valid;
	logic s2_done;
	crc_t s2_crc;
	crc_t s2_state;
	logic [63:0] s2_data;
	logic [2:0] s2_len;
	crc_t s2_x32;

	// Stage 3 has the word selected with 0..3 bytes left
	logic s3_valid;
	logic s3_done;
	crc_t s3_crc;
	crc_t s3_state;
	logic [31:0] s3_data;
	logic [1:0] s3_len;
	crc_t s3_var;

	// Stage 4 holds the final reflected state
	logic s4_valid;
	crc_t s4_crc;

	// Upper 8 bytes of the beat
	assign s0_x64 = crc32_bytes(s0_state, s0_data, 5'd8);
	// Upper 4 bytes of the selected half
	assign s2_x32 = crc32_bytes(s2_state, {s2_data[63:32], 96'h0}, 5'd4);
	// 0..3 bytes of the selected word
	assign s3_var = crc32_bytes(s3_state, {s3_data, 96'h0}, {3'b000, s3_len});

	// Valid chain
	always_ff @(posedge clk) begin
		if (reset) begin
			s0_valid <= 1'b0;
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			s3_valid <= 1'b0;
			s4_valid <= 1'b0;
		end else begin
			s0_valid <= update && last;
			s1_valid <= s0_valid;
			s2_valid <= s1_valid;
			s3_valid <= s2_valid;
			s4_valid <= s3_valid;
		end
	end

	// Payload stages
	always_ff @(posedge clk) begin
		// A full 16-byte last beat is finished right here
		s0_done <= bytes[4];
		s0_crc <= crc_full;
		s0_state <= crc_run;
		s0_data <= data;
		s0_len <= bytes[3:0];

		s1_done <= s0_done;
		s1_crc <= s0_crc;
		s1_state <= s0_state;
		s1_data <= s0_data;
		s1_len <= s0_len;
		s1_x64 <= s0_x64;

		// Eight or more bytes keep the x64 state and move to the low half
		if (s1_len[3]) begin
			s2_state <= s1_x64;
			s2_data <= s1_data[63:0];
		end else begin
			s2_state <= s1_state;
			s2_data <= s1_data[127:64];
		end
		s2_len <= s1_len[2:0];
		if (!s1_done && s1_len == 4'd8) begin
			s2_done <= 1'b1;
			s2_crc <= s1_x64;
		end else begin
			s2_done <= s1_done;
			s2_crc <= s1_crc;
		end

		// Four or more left take the x32 step and move to the low word
		if (s2_len[2]) begin
			s3_state <= s2_x32;
			s3_data <= s2_data[31:0];
		end else begin
			s3_state <= s2_state;
			s3_data <= s2_data[63:32];
		end
		s3_len <= s2_len[1:0];
		if (!s2_done && s2_len == 3'd4) begin
			s3_done <= 1'b1;
			s3_crc <= s2_x32;
		end else begin
			s3_done <= s2_done;
			s3_crc <= s2_crc;
		end

		// Remaining 1..3 bytes
		s4_crc <= s3_done ? s3_crc : s3_var;
	end

	// Result straight off stage 4
	assign res_valid = s4_valid;
	// Final complement is already in zlib bit order
	assign res_crc = ~s4_crc;

	////////////////////////////////////////////////////////////
	// Checks

	// Admission holds off while reset is high
	a_no_update_in_reset: assert property (
		@(posedge clk) reset |-> (update !== 1'b1)
	);

	// Every last beat produces its result a fixed time later
	a_result_latency: assert property (
		@(posedge clk) disable iff (reset)
		update && last |-> ##(`ETH_CRC_LATENCY) res_valid
	);

endmodule

// ==== rtl/fcs_admit.sv ====
`timescale 1ns/10ps
`include "eth_crc_cfg.svh"

module fcs_admit (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input logic [`ETH_BEAT_BYTES*8-1:0] in_data,
	input logic [4:0] in_bytes,
	input logic in_last,
	output logic in_ready,
	eth_beat_if.source beat_out,
	output logic crc_update,
	output logic crc_last,
	output logic [`ETH_BEAT_BYTES*8-1:0] crc_data,
	output logic [4:0] crc_bytes,
	input logic credit_release
);

	localparam int CW = $clog2(`ETH_CRC_FIFO_DEPTH + 1);

	// Frames whose last beat is in but whose CRC the join has not taken yet
	logic [CW-1:0] credits;
	// Low through reset, high from the first cycle after
	logic running;
	logic credit_free;
	logic accept;

	assign credit_free = (credits < CW'(`ETH_CRC_FIFO_DEPTH));
	assign in_ready = running && beat_out.ready && credit_free;
	assign accept = in_valid && in_ready;

	// Beat FIFO and CRC engine see the same accepted beat
	assign beat_out.valid = accept;
	assign beat_out.beat = '{data: in_data, bytes: in_bytes, last: in_last};

	assign crc_update = accept;
	assign crc_last = in_last;
	assign crc_data = in_data;
	assign crc_bytes = in_bytes;

	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			credits <= '0;
		end else begin
			running <= 1'b1;
			// Take a credit on a last beat, give one back on a join pop
			case ({accept && in_last, credit_release})
				2'b10: credits <= credits + 1'b1;
				2'b01: credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// Last beats carry 1..16 bytes
	a_last_bytes: assert property (
		@(posedge clk) disable iff (reset)
		in_valid && in_last |-> (in_bytes inside {[5'd1:5'd16]})
	);

endmodule

// ==== rtl/fcs_join.sv ====
`timescale 1ns/10ps

module fcs_join import eth_crc_pkg::*; (
	eth_beat_if.sink beat_in,
	input logic crc_valid,
	output logic crc_ready,
	input crc_t crc_data,
	output logic out_valid,
	output logic [BEAT_BITS-1:0] out_data,
	output logic [4:0] out_bytes,
	output logic out_last,
	output crc_t out_fcs,
	input logic out_ready,
	output logic credit_release
);

	// Head of the beat FIFO is the end of a frame
	logic head_last;
	// Head may go out now
	logic beat_go;

	assign head_last = beat_in.valid && beat_in.beat.last;
	// Non-last beats flow freely, a last beat waits for its CRC
	assign beat_go = !beat_in.beat.last || crc_valid;

	assign out_valid = beat_in.valid && beat_go;
	assign out_data = beat_in.beat.data;
	assign out_bytes = beat_in.beat.bytes;
	assign out_last = beat_in.beat.last;
	assign out_fcs = crc_data;

	assign beat_in.ready = out_ready && beat_go;

	// Pop the CRC together with its last beat
	assign crc_ready = out_ready && head_last;
	assign credit_release = crc_ready && crc_valid;

	// A waiting CRC means its last beat is still queued in the beat FIFO
	a_crc_has_beat: assert property (
		@(posedge beat_in.clk) disable iff (beat_in.reset)
		crc_valid |-> beat_in.valid
	);

endmodule

// ==== rtl/eth_fcs_top.sv ====
`timescale 1ns/10ps
`include "eth_crc_cfg.svh"

module eth_fcs_top import eth_crc_pkg::*; (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input logic [BEAT_BITS-1:0] in_data,
	input logic [4:0] in_bytes,
	input logic in_last,
	output logic in_ready,
	output logic out_valid,
	output logic [BEAT_BITS-1:0] out_data,
	output logic [4:0] out_bytes,
	output logic out_last,
	output crc_t out_fcs,
	input logic out_ready
);

	// Admit gate to CRC engine
	logic crc_update;
	logic crc_last;
	logic [4:0] crc_bytes;
	logic [BEAT_BITS-1:0] crc_data;

	// CRC engine to result FIFO to join
	logic res_valid;
	crc_t res_crc;
	logic fifo_crc_valid;
	logic fifo_crc_ready;
	crc_t fifo_crc_data;
	logic credit_release;

	////////////////////////////////////////////////////////////
	// Beat streams

	eth_beat_if u_in_if (.clk(clk), .reset(reset));
	eth_beat_if u_beat_if (.clk(clk), .reset(reset));
	eth_beat_if u_join_if (.clk(clk), .reset(reset));

	// Input pins onto a beat stream
	assign u_in_if.valid = in_valid;
	assign u_in_if.beat = '{data: in_data, bytes: in_bytes, last: in_last};
	assign in_ready = u_in_if.ready;

	////////////////////////////////////////////////////////////
	// Datapath

	fcs_admit u_fcs_admit (
		.clk(clk),
		.reset(reset),
		.in_valid(u_in_if.valid),
		.in_data(u_in_if.beat.data),
		.in_bytes(u_in_if.beat.bytes),
		.in_last(u_in_if.beat.last),
		.in_ready(u_in_if.ready),
		.beat_out(u_beat_if.source),
		.crc_update(crc_update),
		.crc_last(crc_last),
		.crc_data(crc_data),
		.crc_bytes(crc_bytes),
		.credit_release(credit_release)
	);

	crc32_x128_pipe u_crc_pipe (
		.clk(clk),
		.reset(reset),
		.update(crc_update),
		.last(crc_last),
		.bytes(crc_bytes),
		.data(crc_data),
		.res_valid(res_valid),
		.res_crc(res_crc)
	);

	stream_fifo #(.payload_t(beat_t), .DEPTH(`ETH_BEAT_FIFO_DEPTH)) u_beat_fifo (
		.clk(clk),
		.reset(reset),
		.wr_valid(u_beat_if.valid),
		.wr_ready(u_beat_if.ready),
		.wr_data(u_beat_if.beat),
		.rd_valid(u_join_if.valid),
		.rd_ready(u_join_if.ready),
		.rd_data(u_join_if.beat)
	);

	// Engine cannot stall, credits keep this one from filling up
	stream_fifo #(.payload_t(crc_t), .DEPTH(`ETH_CRC_FIFO_DEPTH)) u_crc_fifo (
		.clk(clk),
		.reset(reset),
		.wr_valid(res_valid),
		.wr_ready(),
		.wr_data(res_crc),
		.rd_valid(fifo_crc_valid),
		.rd_ready(fifo_crc_ready),
		.rd_data(fifo_crc_data)
	);

	fcs_join u_fcs_join (
		.beat_in(u_join_if.sink),
		.crc_valid(fifo_crc_valid),
		.crc_ready(fifo_crc_ready),
		.crc_data(fifo_crc_data),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_bytes(out_bytes),
		.out_last(out_last),
		.out_fcs(out_fcs),
		.out_ready(out_ready),
		.credit_release(credit_release)
	);

endmodule

// ==== dv/eth_fcs_tb.sv ====
`timescale 1ns/10ps
`include "eth_crc_cfg.svh"

module eth_fcs_tb import eth_crc_pkg::*; ();

	////////////////////////////////////////////////////////////
	// Setup

	localparam int CLK_PERIOD = 40;
	// Inputs change this long after the rising edge
	localparam int DRIVE_DELAY = 2;
	localparam int WAIT_LIMIT = 1000;
	localparam int DRAIN_LIMIT = 5000;
	// Output held off this long in the back-pressure burst
	localparam int STALL_CYCLES = 300;

	typedef logic [7:0] byte_q_t[$];

	logic clk;
	logic reset;
	logic in_valid;
	logic [BEAT_BITS-1:0] in_data;
	logic [4:0] in_bytes;
	logic in_last;
	logic in_ready;
	logic out_valid;
	logic [BEAT_BITS-1:0] out_data;
	logic [4:0] out_bytes;
	logic out_last;
	crc_t out_fcs;
	logic out_ready;

	// Expected output beats and frame CRCs in send order
	beat_t exp_beats[$];
	crc_t exp_fcs[$];

	// Scoreboard counters
	int errors;
	int timeouts;
	int beats_in;
	int beats_out;
	int frames_in;
	int frames_out;
	// Raised when a wait loop gives up so the source stops
	bit hung;
	bit stall;
	bit saw_drop;

	eth_fcs_top u_eth_fcs_top (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_data(in_data),
		.in_bytes(in_bytes),
		.in_last(in_last),
		.in_ready(in_ready),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_bytes(out_bytes),
		.out_last(out_last),
		.out_fcs(out_fcs),
		.out_ready(out_ready)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Model and compare

	// Bit-serial reflected CRC-32 with all ones in and complemented out
	function automatic crc_t model_crc(byte_q_t frame);
		crc_t c;
		logic fb;
		c = 32'hFFFF_FFFF;
		foreach (frame[i]) begin
			for (int k = 0; k < 8; k++) begin
				fb = c[0] ^ frame[i][k];
				c = c >> 1;
				if (fb)
					c = c ^ 32'hEDB8_8320;
			end
		end
		return ~c;
	endfunction

	task automatic check_equal(input logic [127:0] got, input logic [127:0] exp,
			input string what);
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Source side

	// Hold one beat until in_ready is seen at a falling edge
	task automatic drive_beat(beat_t b);
		int waited;
		bit taken;
		waited = 0;
		taken = 1'b0;
		in_valid = 1'b1;
		in_data = b.data;
		in_bytes = b.bytes;
		in_last = b.last;
		while (!taken && !hung) begin
			@(negedge clk);
			// in_ready does not depend on in_valid and is stable until the edge
			if (in_ready) begin
				taken = 1'b1;
			end else begin
				waited++;
				if (waited >= WAIT_LIMIT) begin
					hung = 1'b1;
					timeouts++;
					$display("Timeout at %0t: in_ready stayed low for %0d cycles",
						$time, waited);
				end
			end
		end
		@(posedge clk);
		#(DRIVE_DELAY);
		in_valid = 1'b0;
		if (taken)
			beats_in++;
	endtask

	task automatic idle_gap();
		repeat ($urandom_range(3)) begin
			@(posedge clk);
			#(DRIVE_DELAY);
		end
	endtask

	// Random frame split into left-aligned beats
	task automatic send_frame(int len, bit gaps);
		byte_q_t frame;
		beat_t b;
		int pos;
		int nb;
		for (int i = 0; i < len; i++)
			frame.push_back(8'($urandom));
		exp_fcs.push_back(model_crc(frame));
		frames_in++;
		pos = 0;
		while (pos < len && !hung) begin
			nb = (len - pos > `ETH_BEAT_BYTES) ? `ETH_BEAT_BYTES : len - pos;
			// Lanes past the byte count get junk the CRC must ignore
			for (int lane = 0; lane < `ETH_BEAT_BYTES; lane++)
				b.data[BEAT_BITS-1-8*lane -: 8] = (lane < nb) ? frame[pos+lane] : 8'($urandom);
			b.last = (pos + nb == len);
			b.bytes = b.last ? 5'(nb) : 5'd16;
			exp_beats.push_back(b);
			if (gaps)
				idle_gap();
			drive_beat(b);
			pos += nb;
		end
	endtask

	// Frames pushed in while the output is held off
	task automatic backpressure_burst();
		fork
			begin
				for (int n = 0; n < 8 && !hung; n++)
					send_frame(1 + $urandom_range(99), 1'b0);
			end
			begin
				@(negedge clk);
				stall = 1'b1;
				repeat (STALL_CYCLES) begin
					@(negedge clk);
					if (in_valid && !in_ready)
						saw_drop = 1'b1;
				end
				stall = 1'b0;
			end
		join
		check_equal(saw_drop, 1'b1, "in_ready drop under held output");
		@(posedge clk);
		#(DRIVE_DELAY);
	endtask

	////////////////////////////////////////////////////////////
	// Sink side

	task automatic take_beat();
		beat_t exp;
		if (exp_beats.size() == 0) begin
			errors++;
			$display("Output beat at %0t with no beat left to expect", $time);
		end else begin
			exp = exp_beats.pop_front();
			beats_out++;
			check_equal(out_data, exp.data, "out_data");
			check_equal(out_bytes, exp.bytes, "out_bytes");
			check_equal(out_last, exp.last, "out_last");
			if (exp.last) begin
				frames_out++;
				if (exp_fcs.size() == 0) begin
					errors++;
					$display("Last beat at %0t with no expected FCS", $time);
				end else begin
					check_equal(out_fcs, exp_fcs.pop_front(), "out_fcs");
				end
			end
		end
	endtask

	// Random ready with beats checked against the queues at the falling edge
	initial begin
		out_ready = 1'b0;
		forever begin
			@(posedge clk);
			#(DRIVE_DELAY);
			out_ready = !stall && ($urandom_range(3) != 0);
			@(negedge clk);
			if (out_valid && out_ready)
				take_beat();
		end
	end

	////////////////////////////////////////////////////////////
	// Sequence

	initial begin
		int waited;
		void'($urandom(32'h79739cda));
		reset = 1'b1;
		in_valid = 1'b0;
		in_data = '0;
		in_bytes = '0;
		in_last = 1'b0;
		errors = 0;
		timeouts = 0;
		hung = 1'b0;
		stall = 1'b0;
		saw_drop = 1'b0;

		for (int i = 0; i < 8; i++) begin
			@(posedge clk);
			#(DRIVE_DELAY);
			check_equal(in_ready, 1'b0, "in_ready in reset");
			check_equal(out_valid, 1'b0, "out_valid in reset");
		end
		reset = 1'b0;
		check_equal(out_valid, 1'b0, "out_valid after reset");

		// in_ready comes up once reset is gone
		waited = 0;
		while (!in_ready && !hung) begin
			@(negedge clk);
			if (!in_ready) begin
				waited++;
				if (waited >= WAIT_LIMIT) begin
					hung = 1'b1;
					timeouts++;
					$display("Timeout at %0t: in_ready never rose after reset", $time);
				end
			end
		end
		@(posedge clk);
		#(DRIVE_DELAY);

		// First frame straight after reset
		send_frame(60, 1'b0);
		// Every last-beat count over single and two-beat frames sent back to back
		for (int len = 1; len <= 2 * `ETH_BEAT_BYTES && !hung; len++)
			send_frame(len, 1'b0);
		for (int n = 0; n < 120 && !hung; n++)
			send_frame(1 + $urandom_range(99), 1'b1);
		if (!hung)
			backpressure_burst();
		for (int n = 0; n < 20 && !hung; n++)
			send_frame(1 + $urandom_range(99), 1'b1);

		// Drain everything still in flight
		waited = 0;
		while (exp_beats.size() != 0 && !hung) begin
			@(posedge clk);
			waited++;
			if (waited >= DRAIN_LIMIT) begin
				hung = 1'b1;
				timeouts++;
				$display("Timeout at %0t: %0d beats never came out", $time, exp_beats.size());
			end
		end
		if (!hung) begin
			check_equal(beats_out, beats_in, "beat count");
			check_equal(frames_out, frames_in, "frame count");
		end

		$display("Done: %0d frames in, %0d frames out, %0d errors, %0d timeouts",
			frames_in, frames_out, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+rtl
rtl/eth_crc_pkg.sv
rtl/eth_beat_if.sv
rtl/stream_fifo.sv
rtl/crc32_x128_pipe.sv
rtl/fcs_admit.sv
rtl/fcs_join.sv
rtl/eth_fcs_top.sv
dv/eth_fcs_tb.sv

// ==== Bender.yml ====
package:
  name: eth_fcs

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/eth_crc_pkg.sv
      - rtl/eth_beat_if.sv
      - rtl/stream_fifo.sv
      - rtl/crc32_x128_pipe.sv
      - rtl/fcs_admit.sv
      - rtl/fcs_join.sv
      - rtl/eth_fcs_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - dv/eth_fcs_tb.sv
